//--- flist.f
source/fp_rename_pkg.sv
source/fp_free_list.sv
source/rename_table_fp.sv
source/fp_rename_stage.sv
test/tb_fp_rename.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FP rename testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fp_rename -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_fp_rename 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- test/tb_fp_rename.sv
`timescale 1ns/10ps

module tb_fp_rename;

    import fp_rename_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_WB     = 2;
    localparam int TIMEOUT    = 20;  // Cycles allowed for a response

    logic                clk;
    logic                rstn;
    rename_req_t         req;
    fp_wb_t [NUM_WB-1:0] wb;
    fp_commit_t          commit;
    fp_recover_t         recover;
    rename_resp_t        resp;
    logic                stall;
    logic                out_of_checkpoints;

    // Reference model with the live map and one saved copy per checkpoint label
    phreg_t        m_map [NUM_ISA_REGISTERS];
    logic          m_rdy [NUM_ISA_REGISTERS];
    phreg_t        m_commit_map [NUM_ISA_REGISTERS];
    phreg_t        m_free [$];         // Speculative free list with the next register at the front
    phreg_t        m_commit_free [$];  // Free list as seen by committed state
    phreg_t        s_map [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic          s_rdy [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t        s_free [NUM_CHECKPOINTS][$];
    checkpoint_ptr m_head;  // Label of the live version
    checkpoint_ptr m_tail;  // Oldest live checkpoint
    int            m_ncp;   // Live checkpoints

    fp_commit_t   pending [$];  // Uncommitted renames in program order
    rename_resp_t last_resp;
    logic         last_stall;

    fp_rename_stage #(
        .NUM_WB (NUM_WB)
    ) i_fp_rename_stage (
        .clk_i                (clk),
        .rstn_i               (rstn),
        .req_i                (req),
        .wb_i                 (wb),
        .commit_i             (commit),
        .recover_i            (recover),
        .resp_o               (resp),
        .stall_o              (stall),
        .out_of_checkpoints_o (out_of_checkpoints)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic reg_t rand_reg();
        return reg_t'($urandom);
    endfunction

    function automatic void clear_inputs();
        req     = '0;  // Idle producer
        wb      = '0;
        commit  = '0;
        recover = '0;
    endfunction

    function automatic void set_request(input reg_t fd, input logic write_fd, input logic ckpt);
        req.valid         = 1'b1;
        req.fs1           = rand_reg();
        req.fs2           = rand_reg();
        req.fs3           = rand_reg();
        req.use_fs1       = 1'b1;
        req.use_fs2       = 1'b1;
        req.use_fs3       = 1'b1;
        req.fd            = fd;
        req.write_fd      = write_fd;
        req.do_checkpoint = ckpt;
    endfunction

    function automatic void set_writeback(input int port, input reg_t r, input phreg_t p);
        wb[port].valid = 1'b1;
        wb[port].vaddr = r;
        wb[port].paddr = p;
    endfunction

    function automatic void reset_model();
        m_free.delete();
        m_commit_free.delete();
        for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
            m_map[j]        = phreg_t'(j);  // Identity map
            m_rdy[j]        = 1'b1;
            m_commit_map[j] = phreg_t'(j);
        end
        for (int j = NUM_ISA_REGISTERS; j < NUM_PHYS_REGISTERS; j++) begin
            m_free.push_back(phreg_t'(j));
            m_commit_free.push_back(phreg_t'(j));
        end
        for (int l = 0; l < NUM_CHECKPOINTS; l++) begin
            s_free[l].delete();
            for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                s_map[l][j] = '0;
                s_rdy[l][j] = 1'b0;
            end
        end
        m_head = '0;
        m_tail = '0;
        m_ncp  = 0;
        pending.delete();
    endfunction

    // Ready bit including a same cycle writeback to the current mapping
    function automatic logic expect_ready(input reg_t r, input logic used);
        logic rdy;
        rdy = m_rdy[r] | ~used;
        for (int w = 0; w < NUM_WB; w++) begin
            if (wb[w].valid && (wb[w].vaddr == r) && (wb[w].paddr == m_map[r])) begin
                rdy = 1'b1;
            end
        end
        return rdy;
    endfunction

    // State change at one clock edge
    function automatic void update_model(input logic grant);
        fp_commit_t entry;
        for (int w = 0; w < NUM_WB; w++) begin
            if (wb[w].valid) begin
                if (m_map[wb[w].vaddr] == wb[w].paddr) m_rdy[wb[w].vaddr] = 1'b1;
                for (int l = 0; l < NUM_CHECKPOINTS; l++) begin
                    if (s_map[l][wb[w].vaddr] == wb[w].paddr) s_rdy[l][wb[w].vaddr] = 1'b1;
                end
            end
        end
        if (commit.valid && commit.write_fd && !recover.recover_commit) begin
            m_commit_map[commit.fd] = commit.new_dst;
            void'(m_commit_free.pop_front());  // Committed instr owns its register
            m_commit_free.push_back(commit.old_dst);
            m_free.push_back(commit.old_dst);  // Free in every view
            for (int l = 0; l < NUM_CHECKPOINTS; l++) s_free[l].push_back(commit.old_dst);
        end
        if (recover.recover_commit) begin
            for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                m_map[j] = m_commit_map[j];
                m_rdy[j] = 1'b1;
            end
            m_free = m_commit_free;
            m_head = '0;
            m_tail = '0;
            m_ncp  = 0;
            pending.delete();  // Nothing uncommitted survives
        end else begin
            m_tail = m_tail + checkpoint_ptr'(recover.delete_checkpoint);
            if (recover.do_recover) begin
                for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                    m_map[j] = s_map[recover.recover_checkpoint][j];
                    m_rdy[j] = s_rdy[recover.recover_checkpoint][j];
                end
                m_free = s_free[recover.recover_checkpoint];
                m_head = recover.recover_checkpoint;
                m_ncp  = int'(checkpoint_ptr'(m_head - m_tail));
            end else begin
                if (recover.delete_checkpoint) m_ncp--;
                if (grant && req.do_checkpoint) begin
                    // Copy taken before this instr writes its destination
                    for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                        s_map[m_head][j] = m_map[j];
                        s_rdy[m_head][j] = m_rdy[j];
                    end
                    s_free[m_head] = m_free;
                    m_head = m_head + checkpoint_ptr'(1);
                    m_ncp++;
                end
                if (grant && req.write_fd) begin
                    entry.valid    = 1'b1;
                    entry.write_fd = 1'b1;
                    entry.fd       = req.fd;
                    entry.new_dst  = m_free[0];
                    entry.old_dst  = m_map[req.fd];
                    pending.push_back(entry);
                    m_map[req.fd] = m_free.pop_front();
                    m_rdy[req.fd] = 1'b0;  // Producer in flight
                end
            end
        end
    endfunction

    // One clock with caller inputs and the response checked a cycle later
    task automatic run_cycle();
        rename_resp_t exp;
        logic         grant;
        logic         write;
        int           waited;
        grant = req.valid && !recover.do_recover && !recover.recover_commit
              && (!req.write_fd || (m_free.size() > 0))
              && (!req.do_checkpoint || (m_ncp < NUM_CHECKPOINTS - 1));
        write          = req.write_fd;
        exp            = '0;
        exp.src1       = m_map[req.fs1];
        exp.rdy1       = expect_ready(req.fs1, req.use_fs1);
        exp.src2       = m_map[req.fs2];
        exp.rdy2       = expect_ready(req.fs2, req.use_fs2);
        exp.src3       = m_map[req.fs3];
        exp.rdy3       = expect_ready(req.fs3, req.use_fs3);
        exp.new_dst    = (m_free.size() > 0) ? m_free[0] : '0;
        exp.old_dst    = m_map[req.fd];
        exp.checkpoint = m_head;
        #(CLK_PERIOD / 4);  // Combinational stall settled
        last_stall = stall;
        check_value("stall_o", 32'(stall), 32'(req.valid && !grant));
        @(posedge clk);
        update_model(grant);
        @(negedge clk);
        clear_inputs();
        if (grant) begin
            waited = 0;
            while (!resp.valid && (waited < TIMEOUT)) begin
                @(negedge clk);
                waited++;
            end
            assert (resp.valid) else stop_run("No response to a granted request in time");
            check_value("resp_o latency", 32'(waited), 32'(0));
            check_value("resp_o.src1", 32'(resp.src1), 32'(exp.src1));
            check_value("resp_o.rdy1", 32'(resp.rdy1), 32'(exp.rdy1));
            check_value("resp_o.src2", 32'(resp.src2), 32'(exp.src2));
            check_value("resp_o.rdy2", 32'(resp.rdy2), 32'(exp.rdy2));
            check_value("resp_o.src3", 32'(resp.src3), 32'(exp.src3));
            check_value("resp_o.rdy3", 32'(resp.rdy3), 32'(exp.rdy3));
            if (write) check_value("resp_o.new_dst", 32'(resp.new_dst), 32'(exp.new_dst));
            check_value("resp_o.old_dst", 32'(resp.old_dst), 32'(exp.old_dst));
            check_value("resp_o.checkpoint", 32'(resp.checkpoint), 32'(exp.checkpoint));
            last_resp = resp;
        end else begin
            check_value("resp_o.valid", 32'(resp.valid), 32'(0));  // Dropped request
        end
        check_value("out_of_checkpoints_o", 32'(out_of_checkpoints),
                    32'(m_ncp == NUM_CHECKPOINTS - 1));
    endtask

    task automatic read_all_registers();
        for (int r = 0; r < 11; r++) begin
            set_request(rand_reg(), 1'b0, 1'b0);
            req.fs1 = reg_t'(3 * r);
            req.fs2 = reg_t'(3 * r + 1);
            req.fs3 = reg_t'(3 * r + 2);  // Last one wraps to 0
            run_cycle();
        end
    endtask

    task automatic reset_state_reads();
        reg_t r;
        check_value("resp_o.valid", 32'(resp.valid), 32'(0));
        check_value("stall_o", 32'(stall), 32'(0));
        check_value("out_of_checkpoints_o", 32'(out_of_checkpoints), 32'(0));
        repeat (8) begin
            r = rand_reg();
            set_request(r, 1'b0, 1'b0);
            req.fs1 = r;
            run_cycle();
            check_value("resp_o.src1", 32'(last_resp.src1), 32'(r));  // Identity map
            check_value("resp_o.old_dst", 32'(last_resp.old_dst), 32'(r));
        end
    endtask

    task automatic allocation_order();
        reg_t fd;
        for (int i = 0; i < 6; i++) begin
            fd = rand_reg();
            set_request(fd, 1'b1, 1'b0);
            run_cycle();  // Back to back renames
            check_value("resp_o.new_dst", 32'(last_resp.new_dst), 32'(NUM_ISA_REGISTERS + i));
        end
        set_request(rand_reg(), 1'b0, 1'b0);
        req.fs1     = fd;
        req.fs2     = fd;
        req.use_fs2 = 1'b0;  // Unused operand reads ready
        run_cycle();
        check_value("resp_o.rdy1", 32'(last_resp.rdy1), 32'(0));
        check_value("resp_o.rdy2", 32'(last_resp.rdy2), 32'(1));
    endtask

    task automatic writeback_wakeup();
        reg_t   r1;
        reg_t   r2;
        reg_t   r3;
        phreg_t p [3];
        r1 = rand_reg();
        r2 = r1 + reg_t'(1);
        r3 = r1 + reg_t'(2);
        set_request(r1, 1'b1, 1'b0);
        run_cycle();
        p[0] = last_resp.new_dst;
        set_request(r2, 1'b1, 1'b0);
        run_cycle();
        p[1] = last_resp.new_dst;
        set_request(r3, 1'b1, 1'b0);
        run_cycle();
        p[2] = last_resp.new_dst;
        set_request(rand_reg(), 1'b0, 1'b0);  // Bypass on both ports
        req.fs1 = r1;
        req.fs2 = r2;
        set_writeback(0, r1, p[0]);
        set_writeback(1, r2, p[1]);
        run_cycle();
        check_value("resp_o.rdy1", 32'(last_resp.rdy1), 32'(1));
        check_value("resp_o.rdy2", 32'(last_resp.rdy2), 32'(1));
        set_writeback(1, r3, p[2]);  // Earlier cycle with no request
        run_cycle();
        set_request(rand_reg(), 1'b0, 1'b0);
        req.fs3 = r3;
        run_cycle();
        check_value("resp_o.rdy3", 32'(last_resp.rdy3), 32'(1));
        set_request(r1, 1'b1, 1'b0);  // Remap r1 before a stale writeback
        run_cycle();
        set_writeback(0, r1, p[0]);
        run_cycle();
        set_request(rand_reg(), 1'b0, 1'b0);
        req.fs1 = r1;
        run_cycle();
        check_value("resp_o.rdy1", 32'(last_resp.rdy1), 32'(0));
    endtask

    task automatic checkpoint_recovery();
        checkpoint_ptr label;
        phreg_t        first_new;
        set_request(rand_reg(), 1'b1, 1'b1);
        run_cycle();
        label     = last_resp.checkpoint;
        first_new = last_resp.new_dst;
        repeat (4) begin
            set_request(rand_reg(), 1'b1, 1'b0);
            run_cycle();
        end
        recover.do_recover         = 1'b1;  // Mispredict
        recover.recover_checkpoint = label;
        run_cycle();
        read_all_registers();
        set_request(rand_reg(), 1'b1, 1'b0);
        run_cycle();
        check_value("resp_o.new_dst", 32'(last_resp.new_dst), 32'(first_new));
        repeat (3) begin
            set_request(rand_reg(), 1'b0, 1'b1);
            run_cycle();
        end
        check_value("out_of_checkpoints_o", 32'(out_of_checkpoints), 32'(1));
        set_request(rand_reg(), 1'b0, 1'b1);
        run_cycle();
        check_value("stall_o", 32'(last_stall), 32'(1));
        recover.delete_checkpoint = 1'b1;  // Oldest branch resolved
        run_cycle();
        check_value("out_of_checkpoints_o", 32'(out_of_checkpoints), 32'(0));
    endtask

    task automatic exception_recovery();
        phreg_t first_uncommitted;
        recover.recover_commit = 1'b1;
        run_cycle();
        repeat (4) begin
            set_request(rand_reg(), 1'b1, 1'b0);
            run_cycle();
        end
        repeat (2) begin
            commit = pending.pop_front();  // In order like the ROB
            run_cycle();
        end
        first_uncommitted = pending[0].new_dst;
        repeat (2) begin
            set_request(rand_reg(), 1'b1, 1'b0);
            run_cycle();
        end
        recover.recover_commit = 1'b1;  // Exception
        run_cycle();
        read_all_registers();
        set_request(rand_reg(), 1'b1, 1'b0);
        run_cycle();
        check_value("resp_o.new_dst", 32'(last_resp.new_dst), 32'(first_uncommitted));
    endtask

    task automatic free_list_exhaustion();
        phreg_t freed;
        recover.recover_commit = 1'b1;
        run_cycle();
        repeat (NUM_PHYS_REGISTERS - NUM_ISA_REGISTERS) begin
            set_request(rand_reg(), 1'b1, 1'b0);
            run_cycle();
        end
        set_request(rand_reg(), 1'b1, 1'b0);  // List empty
        run_cycle();
        check_value("stall_o", 32'(last_stall), 32'(1));
        set_request(rand_reg(), 1'b0, 1'b0);
        run_cycle();
        check_value("stall_o", 32'(last_stall), 32'(0));
        commit = pending.pop_front();
        freed  = commit.old_dst;
        run_cycle();
        set_request(rand_reg(), 1'b1, 1'b0);
        run_cycle();
        check_value("resp_o.new_dst", 32'(last_resp.new_dst), 32'(freed));
    endtask

    initial begin
        void'($urandom(32'h7f64));
        rstn = 1'b0;
        clear_inputs();
        reset_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        reset_state_reads();
        allocation_order();
        writeback_wakeup();
        checkpoint_recovery();
        exception_recovery();
        free_list_exhaustion();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- source/fp_rename_stage.sv
`timescale 1ns/10ps

module fp_rename_stage #(
    parameter int NUM_WB = 2  // Writeback ports into the table
) (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  fp_rename_pkg::rename_req_t         req_i,      // Decoded instruction
    input  fp_rename_pkg::fp_wb_t [NUM_WB-1:0] wb_i,       // Wakeup from execution
    input  fp_rename_pkg::fp_commit_t          commit_i,   // From reorder buffer
    input  fp_rename_pkg::fp_recover_t         recover_i,
    output fp_rename_pkg::rename_resp_t        resp_o,     // Valid one cycle after grant
    output logic                               stall_o,    // Request not taken
    output logic                               out_of_checkpoints_o
);

    import fp_rename_pkg::*;

    logic          grant;         // Stage 1 accepts the request
    phreg_t        new_dst;       // Register popped from the free list
    checkpoint_ptr version_head;  // Live table version, labels free list copies

    // Stage 1, allocation and acceptance
    fp_free_list i_fp_free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .commit_i             (commit_i),
        .recover_i            (recover_i),
        .version_head_i       (version_head),
        .out_of_checkpoints_i (out_of_checkpoints_o),
        .grant_o              (grant),
        .new_dst_o            (new_dst),
        .stall_o              (stall_o)
    );

    // Stage 2, mapping and checkpoints
    rename_table_fp #(
        .NUM_WB (NUM_WB)
    ) i_rename_table_fp (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .grant_i              (grant),
        .new_dst_i            (new_dst),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .recover_i            (recover_i),
        .resp_o               (resp_o),
        .version_head_o       (version_head),
        .out_of_checkpoints_o (out_of_checkpoints_o)  // Also blocks checkpoints in stage 1
    );

endmodule

//--- source/rename_table_fp.sv
`timescale 1ns/10ps

module rename_table_fp #(
    parameter int NUM_WB = 2  // Writeback ports
) (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    input  fp_rename_pkg::rename_req_t               req_i,
    input  logic                                     grant_i,    // Request accepted
    input  fp_rename_pkg::phreg_t                    new_dst_i,  // Register from free list
    input  fp_rename_pkg::fp_wb_t [NUM_WB-1:0]       wb_i,
    input  fp_rename_pkg::fp_commit_t                commit_i,
    input  fp_rename_pkg::fp_recover_t               recover_i,
    output fp_rename_pkg::rename_resp_t              resp_o,
    output fp_rename_pkg::checkpoint_ptr             version_head_o,
    output logic                                     out_of_checkpoints_o
);

    import fp_rename_pkg::*;

    typedef logic [$clog2(NUM_CHECKPOINTS):0] ckpt_count_t;  // One bit wider than label

    // Speculative tables, one copy per version, plus committed map
    phreg_t map_table    [NUM_ISA_REGISTERS][NUM_CHECKPOINTS];
    logic   ready_table  [NUM_ISA_REGISTERS][NUM_CHECKPOINTS];
    phreg_t commit_table [NUM_ISA_REGISTERS];

    checkpoint_ptr version_head;   // Live version
    checkpoint_ptr version_tail;   // Oldest live checkpoint
    checkpoint_ptr next_version;   // Version opened by a checkpoint
    checkpoint_ptr write_version;  // Version that takes the new dst
    checkpoint_ptr tail_next;
    ckpt_count_t   num_checkpoints;

    logic checkpoint_enable;
    logic write_enable;
    logic commit_enable;

    // Source lookup with writeback bypass
    reg_t   src_reg [3];
    logic   use_src [3];
    phreg_t src_map [3];
    logic   src_rdy [3];

    logic wb_set [NUM_WB][NUM_CHECKPOINTS];  // Ready bit to set per port and version

    rename_resp_t resp_d;
    rename_resp_t resp_q;

    // Free list already checked recovery and checkpoint room
    assign checkpoint_enable = grant_i & req_i.do_checkpoint;
    assign write_enable      = grant_i & req_i.write_fd;
    assign commit_enable     = commit_i.valid & commit_i.write_fd & ~recover_i.recover_commit;

    assign next_version  = version_head + checkpoint_ptr'(1);
    assign write_version = checkpoint_enable ? next_version : version_head;  // Snapshot first
    assign tail_next     = version_tail + checkpoint_ptr'(recover_i.delete_checkpoint);

    always_comb begin
        src_reg[0] = req_i.fs1;
        src_reg[1] = req_i.fs2;
        src_reg[2] = req_i.fs3;
        use_src[0] = req_i.use_fs1;
        use_src[1] = req_i.use_fs2;
        use_src[2] = req_i.use_fs3;
        for (int s = 0; s < 3; s++) begin
            src_map[s] = map_table[src_reg[s]][version_head];
            src_rdy[s] = ready_table[src_reg[s]][version_head] | ~use_src[s];  // Unused reads ready
            for (int w = 0; w < NUM_WB; w++) begin
                // Same cycle writeback to the current mapping
                if (wb_i[w].valid && (wb_i[w].vaddr == src_reg[s])
                        && (wb_i[w].paddr == src_map[s])) begin
                    src_rdy[s] = 1'b1;
                end
            end
        end
    end

    // Wakeup in every version still holding the written register
    always_comb begin
        phreg_t wb_map;
        for (int w = 0; w < NUM_WB; w++) begin
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                // Version being opened gets its content from the live one
                if (checkpoint_enable && (checkpoint_ptr'(v) == next_version)) begin
                    wb_map = map_table[wb_i[w].vaddr][version_head];
                end else begin
                    wb_map = map_table[wb_i[w].vaddr][v];
                end
                wb_set[w][v] = wb_i[w].valid && (wb_map == wb_i[w].paddr)
                             && !(write_enable && (wb_i[w].vaddr == req_i.fd)
                                  && (checkpoint_ptr'(v) == write_version));  // Overwritten now
            end
        end
    end

    always_comb begin
        resp_d.valid      = grant_i;
        resp_d.src1       = src_map[0];
        resp_d.rdy1       = src_rdy[0];
        resp_d.src2       = src_map[1];
        resp_d.rdy2       = src_rdy[1];
        resp_d.src3       = src_map[2];
        resp_d.rdy3       = src_rdy[2];
        resp_d.new_dst    = new_dst_i;
        resp_d.old_dst    = map_table[req_i.fd][version_head];
        resp_d.checkpoint = version_head;  // Holds mapping before this instr
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Identity map, all ready
            for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                map_table[j][0]   <= phreg_t'(j);
                ready_table[j][0] <= 1'b1;
                commit_table[j]   <= phreg_t'(j);
            end
            version_head    <= '0;
            version_tail    <= '0;
            num_checkpoints <= '0;
        end else if (recover_i.recover_commit) begin
            // Exception, committed map becomes version 0
            for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                map_table[j][0]   <= commit_table[j];
                ready_table[j][0] <= 1'b1;  // Committed values are all written
            end
            version_head    <= '0;
            version_tail    <= '0;
            num_checkpoints <= '0;  // Drop all checkpoints
        end else begin
            version_tail <= tail_next;

            if (recover_i.do_recover) begin
                // Mispredict, no rename this cycle
                version_head    <= recover_i.recover_checkpoint;
                num_checkpoints <= ckpt_count_t'(checkpoint_ptr'(recover_i.recover_checkpoint
                                                                 - tail_next));
            end else begin
                num_checkpoints <= num_checkpoints + ckpt_count_t'(checkpoint_enable)
                                 - ckpt_count_t'(recover_i.delete_checkpoint);

                if (checkpoint_enable) begin
                    // Live version frozen, renaming continues in the next one
                    for (int i = 0; i < NUM_ISA_REGISTERS; i++) begin
                        map_table[i][next_version]   <= map_table[i][version_head];
                        ready_table[i][next_version] <= ready_table[i][version_head];
                    end
                    version_head <= next_version;
                end

                if (write_enable) begin
                    map_table[req_i.fd][write_version]   <= new_dst_i;
                    ready_table[req_i.fd][write_version] <= 1'b0;  // Producer in flight
                end
            end

            if (commit_enable) begin
                commit_table[commit_i.fd] <= commit_i.new_dst;
            end

            // Last, so it wins over the snapshot copy
            for (int w = 0; w < NUM_WB; w++) begin
                for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                    if (wb_set[w][v]) begin
                        ready_table[wb_i[w].vaddr][v] <= 1'b1;
                    end
                end
            end
        end
    end

    // Response one cycle after grant
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_q.valid <= 1'b0;
        end else begin
            resp_q <= resp_d;
        end
    end

    assign resp_o               = resp_q;
    assign version_head_o       = version_head;
    assign out_of_checkpoints_o = (num_checkpoints == ckpt_count_t'(NUM_CHECKPOINTS - 1));

endmodule

//--- source/fp_free_list.sv
`timescale 1ns/10ps

module fp_free_list (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fp_rename_pkg::rename_req_t  req_i,
    input  fp_rename_pkg::fp_commit_t   commit_i,
    input  fp_rename_pkg::fp_recover_t  recover_i,
    input  fp_rename_pkg::checkpoint_ptr version_head_i,  // Current table version
    input  logic                        out_of_checkpoints_i,
    output logic                        grant_o,
    output fp_rename_pkg::phreg_t       new_dst_o,
    output logic                        stall_o
);

    import fp_rename_pkg::*;

    typedef logic [$clog2(NUM_FREE_ENTRIES):0] count_t;  // Holds 0 to 32

    // Circular list of free physical registers
    phreg_t    free_list [NUM_FREE_ENTRIES];
    free_ptr_t head;         // Next register to hand out
    free_ptr_t commit_head;  // Head as seen by committed state
    free_ptr_t tail;         // Next slot for a released register
    count_t    free_count;

    // Saved head and count per checkpoint slot
    free_ptr_t saved_head  [NUM_CHECKPOINTS];
    count_t    saved_count [NUM_CHECKPOINTS];

    logic          pop;
    logic          push;
    logic          ckpt;
    checkpoint_ptr save_slot;
    checkpoint_ptr load_slot;

    // Acceptance, all request checks live here
    assign grant_o = req_i.valid
                   & ~recover_i.do_recover
                   & ~recover_i.recover_commit
                   & (~req_i.write_fd | (free_count != '0))    // Need a free register
                   & (~req_i.do_checkpoint | ~out_of_checkpoints_i);
    assign stall_o   = req_i.valid & ~grant_o;  // Producer holds the request
    assign new_dst_o = free_list[head];

    assign pop  = grant_o & req_i.write_fd;
    assign ckpt = grant_o & req_i.do_checkpoint;
    // Commit is dropped while returning to committed state
    assign push = commit_i.valid & commit_i.write_fd & ~recover_i.recover_commit;

    // Copy sits next to the table version opened by the checkpoint
    assign save_slot = version_head_i + checkpoint_ptr'(1);
    assign load_slot = recover_i.recover_checkpoint + checkpoint_ptr'(1);

    // Pointers and count
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head        <= '0;
            commit_head <= '0;
            tail        <= '0;
            free_count  <= count_t'(NUM_FREE_ENTRIES);  // Starts full
        end else begin
            if (push) begin
                tail        <= tail + free_ptr_t'(1);
                commit_head <= commit_head + free_ptr_t'(1);  // Committed instr leaves the window
            end
            if (recover_i.recover_commit) begin
                // Every uncommitted register comes back
                head       <= commit_head;
                free_count <= count_t'(NUM_FREE_ENTRIES);
            end else if (recover_i.do_recover) begin
                head       <= saved_head[load_slot];
                free_count <= saved_count[load_slot] + count_t'(push);
            end else begin
                head       <= head + free_ptr_t'(pop);
                free_count <= free_count - count_t'(pop) + count_t'(push);
            end
        end
    end

    // List contents, physical 32 to 63 out of reset
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_FREE_ENTRIES; i++) begin
                free_list[i] <= phreg_t'(NUM_ISA_REGISTERS + i);
            end
        end else if (push) begin
            free_list[tail] <= commit_i.old_dst;  // Released mapping
        end
    end

    // Checkpoint copies
    always_ff @(posedge clk_i) begin
        // Released registers stay free after any later recovery
        for (int j = 0; j < NUM_CHECKPOINTS; j++) begin
            if (push) begin
                saved_count[j] <= saved_count[j] + count_t'(1);
            end
        end
        if (ckpt) begin
            saved_head[save_slot]  <= head;  // Head before this pop
            saved_count[save_slot] <= free_count + count_t'(push);
        end
    end

endmodule

//--- source/fp_rename_pkg.sv
package fp_rename_pkg;

    // Register file sizes
    localparam int NUM_ISA_REGISTERS  = 32;  // Architectural FP registers
    localparam int NUM_PHYS_REGISTERS = 64;  // Physical FP registers
    localparam int NUM_CHECKPOINTS    = 4;   // Table copies, at most 3 live checkpoints
    localparam int NUM_FREE_ENTRIES   = NUM_PHYS_REGISTERS - NUM_ISA_REGISTERS;

    typedef logic [$clog2(NUM_ISA_REGISTERS)-1:0]  reg_t;           // Architectural number
    typedef logic [$clog2(NUM_PHYS_REGISTERS)-1:0] phreg_t;         // Physical number
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0]    checkpoint_ptr;  // Checkpoint label
    typedef logic [$clog2(NUM_FREE_ENTRIES)-1:0]   free_ptr_t;      // Free list index

    // Decoded instruction as seen by rename
    typedef struct packed {
        logic valid;
        reg_t fs1;
        reg_t fs2;
        reg_t fs3;
        logic use_fs1;
        logic use_fs2;
        logic use_fs3;
        reg_t fd;
        logic write_fd;
        logic do_checkpoint;  // Branch, snapshot the tables
    } rename_req_t;

    typedef struct packed {
        logic          valid;
        phreg_t        src1;
        logic          rdy1;
        phreg_t        src2;
        logic          rdy2;
        phreg_t        src3;
        logic          rdy3;
        phreg_t        new_dst;
        phreg_t        old_dst;     // Previous mapping of fd, freed at commit
        checkpoint_ptr checkpoint;  // Label to recover to
    } rename_resp_t;

    typedef struct packed {
        logic   valid;
        reg_t   vaddr;
        phreg_t paddr;
    } fp_wb_t;

    typedef struct packed {
        logic   valid;
        logic   write_fd;
        reg_t   fd;
        phreg_t new_dst;
        phreg_t old_dst;
    } fp_commit_t;

    typedef struct packed {
        logic          recover_commit;  // Exception, back to committed state
        logic          do_recover;      // Mispredict, back to a checkpoint
        checkpoint_ptr recover_checkpoint;
        logic          delete_checkpoint;  // Oldest checkpoint resolved
    } fp_recover_t;

endpackage
